/* mipsProcessor.f */
rtl/mipsPkg.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/memory.sv
rtl/controlUnit.sv
rtl/datapath.sv
rtl/mipsProcessor.sv
bench/mipsProps.sv
bench/mipsProcessorTb.sv

/* build.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module mipsProcessorTb -f mipsProcessor.f
output=$(./obj_dir/VmipsProcessorTb 2>&1)
echo "$output"
echo "$output" | grep -qx "Result: PASSED"

/* bench/mipsProcessorTb.sv */
module mipsProcessorTb import mipsPkg::*; ();

	localparam int TimeoutCycles = 200;
	localparam int ResetCycles = 5;
	localparam logic [15:0] DataAddr = 16'd400; // Word 100 lies past the program

	logic CLK = 1'b0;
	logic reset;
	progT prog;
	retireT retire;
	wordT dataOut;
	wordT instrWords[$]; // Memory image from word 0
	string names[$]; // Expected retires in program order
	regIndexT expDest[$];
	wordT expData[$];
	bit fromAlu[$]; // Retired value also seen on dataOut
	wordT modelRegs [32];
	wordT modelMem [128];
	int failCount = 0;
	int passCount = 0;

	always #10 CLK = ~CLK;

	mipsProcessor #(.MemWords(128)) u_mipsProcessor (.*);

	function automatic wordT encodeRType(aluOpT funct, regIndexT rd, regIndexT rs, regIndexT rt);
		return {6'b000000, rs, rt, rd, 5'b00000, funct};
	endfunction

	function automatic wordT encodeIType(opcodeT op, regIndexT rt, regIndexT rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Reference model step that also appends to image and expected list
	task automatic queueInstruction(input string name, input wordT instr);
		wordT a, b, sext, addr, value;
		regIndexT dest;
		bit writes;
		a = modelRegs[instr[25:21]];
		b = modelRegs[instr[20:16]];
		sext = {{16{instr[15]}}, instr[15:0]};
		addr = a + sext; // ADDI sum and LW/SW address
		dest = instr[20:16];
		value = '0;
		writes = 1'b1;
		case (opcodeT'(instr[31:26]))
			opRType: begin
				dest = instr[15:11];
				case (aluOpT'(instr[5:0]))
					aluAdd: value = a + b;
					aluSub: value = a - b;
					aluAnd: value = a & b;
					aluOr: value = a | b;
					aluXor: value = a ^ b;
					aluNor: value = ~(a | b);
					aluSlt: value = wordT'($signed(a) < $signed(b));
					aluSltu: value = wordT'(a < b);
					aluSllv: value = a << b[4:0]; // Value from rs and amount from rt
					aluSrlv: value = a >> b[4:0];
					aluSrav: value = $signed(a) >>> b[4:0];
					default: writes = 1'b0;
				endcase
			end
			opAddi: value = addr;
			opSlti: value = wordT'($signed(a) < $signed(sext));
			opAndi: value = a & {16'h0000, instr[15:0]}; // Zero extended
			opOri: value = a | {16'h0000, instr[15:0]};
			opXori: value = a ^ {16'h0000, instr[15:0]};
			opLui: value = {instr[15:0], 16'h0000};
			opLw: value = modelMem[addr[8:2]];
			opSw: begin
				modelMem[addr[8:2]] = b;
				writes = 1'b0;
			end
			default: writes = 1'b0; // Unknown opcode
		endcase
		instrWords.push_back(instr);
		if (writes) begin
			if (dest != 5'd0)
				modelRegs[dest] = value;
			names.push_back(name);
			expDest.push_back(dest);
			expData.push_back(value);
			fromAlu.push_back(instr[31:26] != opLw); // LW data skips the ALU
		end
	endtask

	task automatic buildProgram();
		queueInstruction("addi r1", encodeIType(opAddi, 5'd1, 5'd0, 16'($urandom)));
		queueInstruction("addi r2 neg", encodeIType(opAddi, 5'd2, 5'd0, 16'($urandom) | 16'h8000));
		queueInstruction("slti r3", encodeIType(opSlti, 5'd3, 5'd2, 16'($urandom)));
		queueInstruction("andi r4", encodeIType(opAndi, 5'd4, 5'd2, 16'($urandom) | 16'h8000));
		queueInstruction("ori r5", encodeIType(opOri, 5'd5, 5'd1, 16'($urandom) | 16'h8000));
		queueInstruction("xori r6", encodeIType(opXori, 5'd6, 5'd2, 16'($urandom) | 16'h8000));
		queueInstruction("lui r7", encodeIType(opLui, 5'd7, 5'd0, 16'($urandom)));
		queueInstruction("add r8", encodeRType(aluAdd, 5'd8, 5'd1, 5'd2));
		queueInstruction("sub r9", encodeRType(aluSub, 5'd9, 5'd1, 5'd7));
		queueInstruction("and r10", encodeRType(aluAnd, 5'd10, 5'd5, 5'd6));
		queueInstruction("or r11", encodeRType(aluOr, 5'd11, 5'd4, 5'd7));
		queueInstruction("xor r12", encodeRType(aluXor, 5'd12, 5'd8, 5'd9));
		queueInstruction("nor r13", encodeRType(aluNor, 5'd13, 5'd1, 5'd2));
		queueInstruction("slt r14", encodeRType(aluSlt, 5'd14, 5'd2, 5'd1));
		queueInstruction("sltu r15", encodeRType(aluSltu, 5'd15, 5'd2, 5'd1));
		queueInstruction("addi r16 amt", encodeIType(opAddi, 5'd16, 5'd0, 16'(1 + $urandom % 31)));
		queueInstruction("sllv r17", encodeRType(aluSllv, 5'd17, 5'd7, 5'd16));
		queueInstruction("srlv r18", encodeRType(aluSrlv, 5'd18, 5'd2, 5'd16));
		queueInstruction("srav r19", encodeRType(aluSrav, 5'd19, 5'd2, 5'd16));
		queueInstruction("sw r12", encodeIType(opSw, 5'd12, 5'd0, DataAddr)); // No retire
		queueInstruction("lw r20", encodeIType(opLw, 5'd20, 5'd0, DataAddr));
		queueInstruction("addi r0", encodeIType(opAddi, 5'd0, 5'd1, 16'($urandom)));
		queueInstruction("add r21 r0", encodeRType(aluAdd, 5'd21, 5'd0, 5'd5));
		queueInstruction("unknown op", {6'h3F, 26'($urandom)});
		queueInstruction("addi r22", encodeIType(opAddi, 5'd22, 5'd20, 16'($urandom)));
	endtask

	// One word per cycle through the load port while reset is held
	task automatic loadProgram();
		for (int i = 0; i < instrWords.size(); i++) begin
			@(posedge CLK);
			prog <= '{write: 1'b1, wordIndex: 7'(i), data: instrWords[i]};
		end
		@(posedge CLK);
		prog <= '0;
	endtask

	task automatic holdReset();
		for (int c = 0; c < ResetCycles; c++) begin
			@(negedge CLK);
			if (retire.valid) begin
				$display("ERROR: retire valid went high while reset was held");
				failCount++;
			end
		end
		@(posedge CLK);
		reset <= 1'b0;
	endtask

	task automatic waitRetire(output bit seen, output wordT execOut);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		execOut = '0;
		while (!seen && cycles < TimeoutCycles) begin
			@(negedge CLK); // Retire record settled
			if (retire.valid)
				seen = 1'b1;
			else begin
				execOut = dataOut; // ALU output in the writing state
				cycles++;
			end
		end
	endtask

	task automatic checkIndex(input string name, input regIndexT expected,
			input regIndexT actual, output bit ok);
		ok = (expected == actual);
		if (!ok)
			$display("FAIL %s dest expected %0d actual %0d", name, expected, actual);
	endtask

	task automatic checkWord(input string name, input wordT expected,
			input wordT actual, output bit ok);
		ok = (expected == actual);
		if (!ok)
			$display("FAIL %s data expected %h actual %h", name, expected, actual);
	endtask

	initial begin
		bit seen;
		bit destOk;
		bit dataOk;
		bit outOk;
		wordT execOut;
		int assertFails;
		void'($urandom(90)); // Seed once
		reset = 1'b1;
		prog = '0;
		foreach (modelRegs[i])
			modelRegs[i] = '0;
		foreach (modelMem[i])
			modelMem[i] = '0;
		buildProgram();
		loadProgram();
		holdReset();
		for (int i = 0; i < expDest.size(); i++) begin
			waitRetire(seen, execOut);
			if (!seen) begin
				$display("ERROR: no register write retired within %0d cycles for %s",
					TimeoutCycles, names[i]);
				failCount++;
				break;
			end
			checkIndex(names[i], expDest[i], retire.dest, destOk);
			checkWord(names[i], expData[i], retire.data, dataOk);
			outOk = 1'b1;
			if (fromAlu[i])
				checkWord({names[i], " dataOut"}, expData[i], execOut, outOk);
			if (destOk && dataOk && outOk) begin
				passCount++;
				$display("PASS %s r%0d = %h", names[i], retire.dest, retire.data);
			end else
				failCount++;
		end
		assertFails = u_mipsProcessor.u_controlUnit.u_mipsProps.assertFails;
		$display("Tests passed %0d, failed %0d, assertion failures %0d",
			passCount, failCount, assertFails);
		if (failCount == 0 && assertFails == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* bench/mipsProps.sv */
module mipsProps import mipsPkg::*; (
	input logic CLK,
	input logic reset,
	input stateT state,
	input ctrlT ctrl
);

	int assertFails = 0; // Failed assertion count

	// First fetch one cycle after reset release
	fetchAfterReset: assert property (@(posedge CLK) $fell(reset) |=> state == stFetch)
		else begin
			assertFails++;
			$error("state is not stFetch one cycle after reset release");
		end

	// Memory write and register write never share a state
	noWriteClash: assert property (@(posedge CLK) disable iff (reset)
		!(ctrl.memWrite && ctrl.regWrite))
		else begin
			assertFails++;
			$error("memWrite and regWrite high in the same cycle");
		end

	pcLoadInFetchWait: assert property (@(posedge CLK) disable iff (reset)
		ctrl.pcLoad |-> state == stFetchWait) // PC steps with the IR load
		else begin
			assertFails++;
			$error("pcLoad high outside stFetchWait");
		end

endmodule

bind controlUnit mipsProps u_mipsProps (
	.CLK(CLK),
	.reset(reset),
	.state(state),
	.ctrl(ctrl)
);

/* rtl/mipsProcessor.sv */
module mipsProcessor import mipsPkg::*; #(
	parameter int MemWords = 128
) (
	input logic CLK,
	input logic reset,
	input progT prog,
	output retireT retire,
	output wordT dataOut
);

	ctrlT ctrl;
	decodeT decode;
	memAddrT memAddr;
	wordT memWriteData;
	wordT memReadData;
	logic memWrite;

	controlUnit u_controlUnit (
		.CLK(CLK),
		.reset(reset),
		.decode(decode),
		.ctrl(ctrl)
	);

	datapath u_datapath (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl),
		.decode(decode),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWrite(memWrite),
		.memReadData(memReadData),
		.retire(retire),
		.aluResult(dataOut) // ALU result is the visible data output
	);

	memory #(.MemWords(MemWords)) u_memory (
		.CLK(CLK),
		.addr(memAddr),
		.writeData(memWriteData),
		.write(memWrite),
		.readData(memReadData),
		.prog(prog)
	);

endmodule

/* rtl/datapath.sv */
module datapath import mipsPkg::*; (
	input logic CLK,
	input logic reset,
	input ctrlT ctrl,
	output decodeT decode,
	output memAddrT memAddr,
	output wordT memWriteData,
	output logic memWrite,
	input wordT memReadData,
	output retireT retire,
	output wordT aluResult
);

	memAddrT pc;
	memAddrT mar;
	wordT ir;
	wordT mdr; // Store data
	wordT regA, regB; // rs, rt from register file
	wordT imm;
	wordT aluB;
	regIndexT dest;
	wordT writeData;

	// Fields straight from IR
	assign decode = '{opcode: opcodeT'(ir[31:26]), funct: ir[5:0]};

	always_ff @(posedge CLK) begin
		if (reset)
			pc <= '0;
		else if (ctrl.pcLoad)
			pc <= pc + 9'd4;
	end

	always_ff @(posedge CLK) begin
		if (reset)
			ir <= '0;
		else if (ctrl.irLoad)
			ir <= memReadData;
	end

	// MAR and MDR, payload only
	always_ff @(posedge CLK) begin
		if (ctrl.marLoad)
			mar <= aluResult[8:0];
		if (ctrl.mdrLoad)
			mdr <= regB;
	end

	assign memAddr = ctrl.addrFromMar ? mar : pc;
	assign memWriteData = mdr;
	assign memWrite = ctrl.memWrite;

	// Immediate, zero or sign extended
	assign imm = ctrl.immZeroExt ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
	assign aluB = ctrl.aluSrcImm ? imm : regB;
	assign dest = ctrl.regDstRd ? ir[15:11] : ir[20:16];
	assign writeData = ctrl.regInMem ? memReadData : aluResult;

	registerFile u_registerFile (
		.CLK(CLK),
		.readA(ir[25:21]),
		.readB(ir[20:16]),
		.write(ctrl.regWrite),
		.dest(dest),
		.writeData(writeData),
		.outA(regA),
		.outB(regB)
	);

	alu u_alu (
		.op(ctrl.aluOp),
		.a(regA),
		.b(aluB),
		.result(aluResult)
	);

	// Retire record, same edge as the register write
	always_ff @(posedge CLK) begin
		if (reset)
			retire <= '0;
		else
			retire <= '{valid: ctrl.regWrite, dest: dest, data: writeData};
	end

endmodule

/* rtl/controlUnit.sv */
module controlUnit import mipsPkg::*; (
	input logic CLK,
	input logic reset,
	input decodeT decode,
	output ctrlT ctrl
);

	stateT state, nextState;
	aluOpT execOp; // Op used in stExecute
	logic execKnown; // Opcode or funct recognised
	logic isRType;
	logic isMem; // LW or SW
	logic immZero; // Logical immediates

	always_ff @(posedge CLK) begin
		if (reset)
			state <= stReset;
		else
			state <= nextState;
	end

	// Operation decode from IR fields
	always_comb begin
		isRType = (decode.opcode == opRType);
		isMem = (decode.opcode == opLw) || (decode.opcode == opSw);
		immZero = 1'b0;
		execKnown = 1'b1;
		execOp = aluAdd;
		case (decode.opcode)
			opRType: begin
				execOp = aluOpT'(decode.funct); // funct is the ALU code
				case (execOp)
					aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
					aluSlt, aluSltu, aluSllv, aluSrlv, aluSrav: execKnown = 1'b1;
					default: execKnown = 1'b0; // Unknown funct, no write
				endcase
			end
			opAddi: execOp = aluAdd;
			opSlti: execOp = aluSlt;
			opAndi: begin
				execOp = aluAnd;
				immZero = 1'b1;
			end
			opOri: begin
				execOp = aluOr;
				immZero = 1'b1;
			end
			opXori: begin
				execOp = aluXor;
				immZero = 1'b1;
			end
			opLui: execOp = aluLui;
			default: execKnown = 1'b0; // Unknown opcode
		endcase
	end

	always_comb begin
		nextState = stFetch;
		case (state)
			stReset: nextState = stFetch;
			stFetch: nextState = stFetchWait;
			stFetchWait: nextState = stDecode;
			stDecode: nextState = isMem ? stMemAddr : stExecute;
			stMemAddr: nextState = (decode.opcode == opLw) ? stLoadRead : stStore;
			stLoadRead: nextState = stLoadWrite;
			default: nextState = stFetch; // Execute, LoadWrite, Store all end here
		endcase
	end

	// Per-state control encoding
	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		case (state)
			stFetchWait: begin
				ctrl.irLoad = 1'b1; // IR takes word read in stFetch
				ctrl.pcLoad = 1'b1;
			end
			stExecute: begin
				ctrl.aluOp = execOp;
				ctrl.aluSrcImm = !isRType;
				ctrl.immZeroExt = immZero;
				ctrl.regDstRd = isRType;
				ctrl.regWrite = execKnown;
			end
			stMemAddr: begin
				ctrl.aluSrcImm = 1'b1; // rs plus signed offset
				ctrl.marLoad = 1'b1;
				ctrl.mdrLoad = (decode.opcode == opSw); // Store data from rt
			end
			stLoadRead: ctrl.addrFromMar = 1'b1;
			stLoadWrite: begin
				ctrl.addrFromMar = 1'b1;
				ctrl.regWrite = 1'b1; // Into rt
				ctrl.regInMem = 1'b1;
			end
			stStore: begin
				ctrl.addrFromMar = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			default: ; // stReset, stFetch, stDecode drive nothing
		endcase
	end

endmodule

/* rtl/memory.sv */
module memory import mipsPkg::*; #(
	parameter int MemWords = 128
) (
	input logic CLK,
	input memAddrT addr,
	input wordT writeData,
	input logic write,
	output wordT readData,
	input progT prog
);

	localparam int IndexBits = $clog2(MemWords);

	wordT mem [MemWords];
	logic [IndexBits-1:0] wordIndex; // From byte address
	logic [IndexBits-1:0] progIndex;

	assign wordIndex = addr[IndexBits+1:2]; // Low two bits dropped
	assign progIndex = prog.wordIndex[IndexBits-1:0];

	// One write port, program load wins
	always_ff @(posedge CLK) begin
		if (prog.write)
			mem[progIndex] <= prog.data;
		else if (write)
			mem[wordIndex] <= writeData;
	end

	// Registered read, word out one cycle after address
	always_ff @(posedge CLK) begin
		readData <= mem[wordIndex];
	end

endmodule

/* rtl/registerFile.sv */
module registerFile import mipsPkg::*; (
	input logic CLK,
	input regIndexT readA,
	input regIndexT readB,
	input logic write,
	input regIndexT dest,
	input wordT writeData,
	output wordT outA,
	output wordT outB
);

	wordT regs [32];

	// Write port, r0 never stored
	always_ff @(posedge CLK) begin
		if (write && dest != '0)
			regs[dest] <= writeData;
	end

	// Both reads registered on the edge
	always_ff @(posedge CLK) begin
		if (readA == '0)
			outA <= '0; // r0 reads zero
		else
			outA <= regs[readA];
		if (readB == '0)
			outB <= '0;
		else
			outB <= regs[readB];
	end

endmodule

/* rtl/alu.sv */
module alu import mipsPkg::*; (
	input aluOpT op,
	input wordT a,
	input wordT b,
	output wordT result
);

	logic [4:0] shamt; // Shift amount, low bits of b

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			aluAdd: begin
				result = a + b; // Wraps, no overflow trap
			end
			aluSub: begin
				result = a - b;
			end
			aluAnd: begin
				result = a & b;
			end
			aluOr: begin
				result = a | b;
			end
			aluXor: begin
				result = a ^ b;
			end
			aluNor: begin
				result = ~(a | b);
			end
			aluSlt: begin
				result = {31'b0, $signed(a) < $signed(b)};
			end
			aluSltu: begin
				result = {31'b0, a < b};
			end
			// Value in a, amount in b
			aluSllv: begin
				result = a << shamt;
			end
			aluSrlv: begin
				result = a >> shamt;
			end
			aluSrav: begin
				result = wordT'($signed(a) >>> shamt); // Sign fill
			end
			aluLui: begin
				result = {b[15:0], 16'b0};
			end
			default: begin
				result = '0; // Undefined op
			end
		endcase
	end

endmodule

/* rtl/mipsPkg.sv */
package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regIndexT;
	typedef logic [8:0] memAddrT; // Byte address, bits 1:0 ignored by memory

	// Primary opcodes, IR[31:26]
	typedef enum logic [5:0] {
		opRType = 6'b000000,
		opAddi = 6'b001000,
		opSlti = 6'b001010,
		opAndi = 6'b001100,
		opOri = 6'b001101,
		opXori = 6'b001110,
		opLui = 6'b001111,
		opLw = 6'b100011,
		opSw = 6'b101011
	} opcodeT;

	// ALU ops share the R-type funct encoding
	typedef enum logic [5:0] {
		aluAdd = 6'b100000,
		aluSub = 6'b100010,
		aluAnd = 6'b100100,
		aluOr = 6'b100101,
		aluXor = 6'b100110,
		aluNor = 6'b100111,
		aluSlt = 6'b101010,
		aluSltu = 6'b101011,
		aluSllv = 6'b000100,
		aluSrlv = 6'b000110,
		aluSrav = 6'b000111,
		aluLui = 6'b111111 // No funct uses it
	} aluOpT;

	typedef enum logic [4:0] {
		stReset,
		stFetch,
		stFetchWait,
		stDecode,
		stExecute,
		stMemAddr,
		stLoadRead,
		stLoadWrite,
		stStore
	} stateT;

	// Control word, one per state
	typedef struct packed {
		logic irLoad;
		logic pcLoad;
		logic marLoad;
		logic mdrLoad;
		logic addrFromMar; // Memory address from MAR, else PC
		logic memWrite;
		logic regWrite;
		logic regDstRd; // rd, else rt
		logic regInMem; // Write back memory word, else ALU result
		logic aluSrcImm;
		logic immZeroExt;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		opcodeT opcode;
		logic [5:0] funct;
	} decodeT;

	typedef struct packed {
		logic valid;
		regIndexT dest;
		wordT data;
	} retireT;

	// Program-load write, used under reset
	typedef struct packed {
		logic write;
		logic [6:0] wordIndex;
		wordT data;
	} progT;

endpackage
